//--- Bender.yml
package:
  name: huff21_decoder

sources:
  - include_dirs:
      - .
    files:
      - huff_pkg.sv
      - huff_symbol_if.sv
      - huff_codebook.sv
      - huff_prefix_stage.sv
      - huff_escape_stage.sv
      - huff21_decoder.sv
  - target: test
    files:
      - huff21_decoder_tb.sv

//--- files.f
+incdir+.
huff_pkg.sv
huff_symbol_if.sv
huff_codebook.sv
huff_prefix_stage.sv
huff_escape_stage.sv
huff21_decoder.sv
huff21_decoder_tb.sv

//--- huff21_decoder.sv
`timescale 1ns/1ns

module huff21_decoder (
	input logic clk,
	input logic rst,
	input logic bit_valid,
	input logic bit_data,
	output logic pair_valid,
	output huff_pkg::huff_val_t x_val,
	output huff_pkg::huff_val_t y_val,
	output logic code_error
);

	// Matched symbol, held until its suffix bits are in
	huff_symbol_if sym ();

	huff_prefix_stage prefix0 (
		.clk(clk),
		.rst(rst),
		.bit_valid(bit_valid),
		.bit_data(bit_data),
		.sym(sym.producer),
		.code_error(code_error)
	);

	huff_escape_stage escape0 (
		.clk(clk),
		.rst(rst),
		.bit_valid(bit_valid),
		.bit_data(bit_data),
		.sym(sym.consumer),
		.pair_valid(pair_valid),
		.x_val(x_val),
		.y_val(y_val)
	);

endmodule

//--- huff21_decoder_tb.sv
`timescale 1ns/1ns

module huff21_decoder_tb;
	import huff_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int MAX_GAP = 3;
	localparam int SEED = 32'hb175_1e9f;
	localparam string DATA_FILE = "huff21_testdata.txt";

	logic clk = 1'b0;
	logic rst;
	logic bit_valid;
	logic bit_data;
	logic pair_valid;
	logic code_error;
	huff_val_t x_val;
	huff_val_t y_val;

	string test_name[$];
	string test_bits[$];
	string test_kind[$];
	int test_gap[$];
	int exp_x[$];
	int exp_y[$];
	bit test_bad[$];

	// Test index and due cycle of each pending event
	int exp_idx[$];
	int exp_stamp[$];

	int cycle = 0;
	int cycle_limit = 0;
	int tests_done = 0;
	int tests_failed = 0;
	int stray_errors = 0;
	bit load_ok = 1'b1;

	huff21_decoder dut0 (
		.clk(clk),
		.rst(rst),
		.bit_valid(bit_valid),
		.bit_data(bit_data),
		.pair_valid(pair_valid),
		.x_val(x_val),
		.y_val(y_val),
		.code_error(code_error)
	);

	always #50 clk = ~clk;

	task automatic check_value(input int idx, input string what,
			input logic signed [63:0] expected, input logic signed [63:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s %s: expected %0d, actual %0d",
				test_name[idx], what, expected, actual);
			test_bad[idx] = 1'b1;
		end
	endtask

	task automatic finish_test(input int idx);
		tests_done++;
		if (test_bad[idx]) begin
			tests_failed++;
			$display("test %s: FAILED", test_name[idx]);
		end else begin
			$display("test %s: ok", test_name[idx]);
		end
	endtask

	task automatic load_tests();
		int fd;
		int n;
		int gap;
		int x;
		int y;
		int total_bits;
		string line;
		string name;
		string bits;
		string kind;
		total_bits = 0;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			load_ok = 1'b0;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %s %d %s %d %d", name, bits, gap, kind, x, y);
			if (n != 6 || !(kind == "pair" || kind == "error" || kind == "reset")) begin
				$display("Malformed line in test data: %s", line);
				load_ok = 1'b0;
				continue;
			end
			test_name.push_back(name);
			test_bits.push_back(bits);
			test_gap.push_back(gap);
			test_kind.push_back(kind);
			exp_x.push_back(x);
			exp_y.push_back(y);
			test_bad.push_back(1'b0);
			for (int i = 0; i < bits.len(); i++)
				if (bits[i] != "_")
					total_bits++;
		end
		$fclose(fd);
		if (test_name.size() == 0)
			load_ok = 1'b0;
		cycle_limit = total_bits * (MAX_GAP + 1) + 20 * test_name.size() + RESET_CYCLES;
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	task automatic drive_bits(input string bits, input int gap, output int last_stamp);
		int n;
		for (int i = 0; i < bits.len(); i++) begin
			if (bits[i] == "_")
				continue;
			if (gap != 0) begin
				n = $urandom % (MAX_GAP + 1);
				repeat (n) begin
					@(posedge clk);
					bit_valid <= 1'b0;
				end
			end
			@(posedge clk);
			bit_valid <= 1'b1;
			bit_data <= (bits[i] == "1");
			last_stamp = cycle;
		end
	endtask

	task automatic run_reset_test(input int idx);
		int stamp;
		@(posedge clk);
		bit_valid <= 1'b0;
		while (exp_idx.size() > 0)
			@(posedge clk);
		drive_bits(test_bits[idx], test_gap[idx], stamp);
		// Enough suffix bits to finish the pair arrive while reset is high
		@(posedge clk);
		rst <= 1'b1;
		bit_valid <= 1'b1;
		bit_data <= 1'b1;
		for (int n = 0; n < 8; n++) begin
			@(posedge clk);
			if (n == 4) begin
				rst <= 1'b0;
				bit_valid <= 1'b0;
			end
			check_value(idx, "pair_valid", 0, pair_valid);
			check_value(idx, "code_error", 0, code_error);
		end
		finish_test(idx);
	endtask

	task automatic run_all_tests();
		int stamp;
		for (int i = 0; i < test_name.size(); i++) begin
			if (test_kind[i] == "reset") begin
				run_reset_test(i);
			end else begin
				drive_bits(test_bits[i], test_gap[i], stamp);
				// Pair shows 3 edges and an error 2 edges after the last bit is driven
				exp_idx.push_back(i);
				exp_stamp.push_back(stamp + ((test_kind[i] == "error") ? 2 : 3));
			end
		end
	endtask

	//////////////////////////////
	// Monitor
	//////////////////////////////
	task automatic sample_outputs();
		int idx;
		if (pair_valid === 1'b1 || code_error === 1'b1) begin
			if (exp_idx.size() == 0 || exp_stamp[0] != cycle) begin
				$display("Unexpected %s at cycle %0d, no test was waiting for it",
					pair_valid ? "pair_valid" : "code_error", cycle);
				stray_errors++;
			end else begin
				idx = exp_idx.pop_front();
				void'(exp_stamp.pop_front());
				check_value(idx, "pair_valid", test_kind[idx] == "pair", pair_valid);
				check_value(idx, "code_error", test_kind[idx] == "error", code_error);
				if (test_kind[idx] == "pair") begin
					check_value(idx, "x_val", exp_x[idx], x_val);
					check_value(idx, "y_val", exp_y[idx], y_val);
				end
				finish_test(idx);
			end
		end
		while (exp_idx.size() > 0 && exp_stamp[0] <= cycle) begin
			idx = exp_idx.pop_front();
			void'(exp_stamp.pop_front());
			$display("%s: expected %s event did not arrive by cycle %0d",
				test_name[idx], test_kind[idx], cycle);
			test_bad[idx] = 1'b1;
			finish_test(idx);
		end
	endtask

	always @(posedge clk) begin
		sample_outputs();
		cycle <= cycle + 1;
	end

	initial begin
		wait (cycle_limit > 0);
		wait (cycle >= cycle_limit);
		$display("Timeout: run did not finish within %0d cycles", cycle_limit);
		$display("Test failures found");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		bit_valid = 1'b0;
		bit_data = 1'b0;
		load_tests();
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		if (load_ok)
			run_all_tests();
		else
			$display("Could not read usable test data from %s", DATA_FILE);
		@(posedge clk);
		bit_valid <= 1'b0;
		while (exp_idx.size() > 0)
			@(posedge clk);
		// Quiet tail to catch late or extra events
		repeat (10) @(posedge clk);
		$display("Summary: %0d of %0d tests done, %0d failed, %0d unexpected events",
			tests_done, test_name.size(), tests_failed, stray_errors);
		if (load_ok && tests_done == test_name.size() && tests_failed == 0 &&
				stray_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- huff21_testdata.txt
# name  bits  gap  kind  x  y
# bits go out left to right and '_' only splits fields, gap 1 adds random idle cycles
# Short codewords
zero_pair 1 0 pair 0 0
x1_pos 011_0 0 pair 1 0
x1_neg 011_1 0 pair -1 0
y1_neg 0101_1 0 pair 0 -1
xy1_mixed 0100_0_1 0 pair 1 -1
y2_pos 001110_0 0 pair 0 2
x2_y1_neg 001101_1_1 0 pair -2 -1
# Escaped magnitudes
x_esc_pos 000001100_00101101_0 0 pair 60 0
y_esc_neg 000010001_11111111_1 0 pair 0 -270
x_esc_zero_lin 00001010_00000000_1_0 0 pair -15 1
y_esc_x1 00001001_0_01010101_0 0 pair 1 100
both_esc 00000011_10000000_0_00000001_1 0 pair 143 -16
# Long codewords in the same back-to-back stream
code14_pair 00000110111101_1_0 0 pair -5 14
code13_pair 0000110000011_0_1 0 pair 3 -13
code12_pair 000011110010_1 0 pair 0 -11
code11_esc 00000000000_0_00001111_1 0 pair 14 -30
# Same kind of stream with idle gaps
zero_pair_gap 1 1 pair 0 0
xy1_mixed_gap 0100_0_1 1 pair 1 -1
both_esc_gap 00000011_10000000_0_00000001_1 1 pair 143 -16
code14_pair_gap 00000110111101_1_0 1 pair -5 14
y_esc_neg_gap 000010001_11111111_1 1 pair 0 -270
code11_esc_gap 00000000000_0_00001111_1 1 pair 14 -30
# Bad 14-bit code, then recovery
bad_code 00000110110000 0 error 0 0
after_bad 0100_1_1 0 pair -1 -1
# Reset in the middle of an escaped pair
reset_mid_pair 000001100_0101 0 reset 0 0
after_reset 001101_0_1 0 pair 2 -1

//--- huff_codebook.sv
`timescale 1ns/1ns
`include "huff_config.svh"

module huff_codebook (
	input huff_pkg::huff_code_buf_t code_buf,
	input huff_pkg::huff_code_len_t code_len,
	output huff_pkg::huff_entry_t entry
);
	import huff_pkg::*;

	typedef struct packed {
		huff_code_len_t len;
		huff_code_buf_t code;
		logic [7:0] xy;
	} cw_t;

	localparam int NUM_CODES = 239;

	//////////////////////////////
	// Codeword, right aligned, with its length and {x, y}
	//////////////////////////////
	localparam cw_t CODES [NUM_CODES] = '{
		'{4'd1, 14'b1, 8'h00}, '{4'd3, 14'b011, 8'h10},
		'{4'd4, 14'b0101, 8'h01}, '{4'd4, 14'b0100, 8'h11},
		'{4'd6, 14'b001110, 8'h02}, '{4'd6, 14'b001100, 8'h12},
		'{4'd6, 14'b001111, 8'h20}, '{4'd6, 14'b001101, 8'h21},
		'{4'd7, 14'b0010100, 8'h13}, '{4'd7, 14'b0010111, 8'h22},
		'{4'd7, 14'b0010101, 8'h31},
		'{4'd8, 14'b00101100, 8'h03}, '{4'd8, 14'b00100011, 8'h14},
		'{4'd8, 14'b00001001, 8'h1f}, '{4'd8, 14'b00100110, 8'h23},
		'{4'd8, 14'b00101101, 8'h30}, '{4'd8, 14'b00100111, 8'h32},
		'{4'd8, 14'b00100100, 8'h41}, '{4'd8, 14'b00011110, 8'h51},
		'{4'd8, 14'b00001010, 8'hf1}, '{4'd8, 14'b00000111, 8'hf2},
		'{4'd8, 14'b00000011, 8'hff},
		'{4'd9, 14'b001001010, 8'h04}, '{4'd9, 14'b000111111, 8'h05},
		'{4'd9, 14'b000010001, 8'h0f}, '{4'd9, 14'b000111110, 8'h15},
		'{4'd9, 14'b000110101, 8'h16}, '{4'd9, 14'b000101111, 8'h17},
		'{4'd9, 14'b001000011, 8'h24}, '{4'd9, 14'b000111010, 8'h25},
		'{4'd9, 14'b000010000, 8'h2f}, '{4'd9, 14'b001000101, 8'h33},
		'{4'd9, 14'b001000000, 8'h34}, '{4'd9, 14'b001001011, 8'h40},
		'{4'd9, 14'b001000100, 8'h42}, '{4'd9, 14'b001000001, 8'h43},
		'{4'd9, 14'b000001001, 8'h4f}, '{4'd9, 14'b001000010, 8'h50},
		'{4'd9, 14'b000111011, 8'h52}, '{4'd9, 14'b000111000, 8'h53},
		'{4'd9, 14'b000110110, 8'h61}, '{4'd9, 14'b000110100, 8'h62},
		'{4'd9, 14'b000110000, 8'h71}, '{4'd9, 14'b000001100, 8'hf0},
		'{4'd9, 14'b000001011, 8'hf3}, '{4'd9, 14'b000001010, 8'hf4},
		'{4'd10, 14'b0001101110, 8'h06}, '{4'd10, 14'b0001011101, 8'h07},
		'{4'd10, 14'b0001010011, 8'h18}, '{4'd10, 14'b0001001011, 8'h19},
		'{4'd10, 14'b0001000100, 8'h1a}, '{4'd10, 14'b0001100111, 8'h26},
		'{4'd10, 14'b0001011010, 8'h27}, '{4'd10, 14'b0001001000, 8'h29},
		'{4'd10, 14'b0001110010, 8'h35}, '{4'd10, 14'b0001100011, 8'h36},
		'{4'd10, 14'b0001010111, 8'h37}, '{4'd10, 14'b0000011010, 8'h3f},
		'{4'd10, 14'b0001110011, 8'h44}, '{4'd10, 14'b0001100101, 8'h45},
		'{4'd10, 14'b0001100110, 8'h54}, '{4'd10, 14'b0000010000, 8'h5f},
		'{4'd10, 14'b0001101111, 8'h60}, '{4'd10, 14'b0001100100, 8'h63},
		'{4'd10, 14'b0000001010, 8'h6f}, '{4'd10, 14'b0001100010, 8'h70},
		'{4'd10, 14'b0001011011, 8'h72}, '{4'd10, 14'b0001011000, 8'h73},
		'{4'd10, 14'b0000001000, 8'h7f}, '{4'd10, 14'b0001010101, 8'h80},
		'{4'd10, 14'b0001010100, 8'h81}, '{4'd10, 14'b0001010001, 8'h82},
		'{4'd10, 14'b0000000111, 8'h8f}, '{4'd10, 14'b0001001100, 8'h91},
		'{4'd10, 14'b0001001001, 8'h92}, '{4'd10, 14'b0001000011, 8'ha2},
		'{4'd10, 14'b0000000100, 8'haf}, '{4'd10, 14'b0000010001, 8'hf5},
		'{4'd10, 14'b0000001011, 8'hf6}, '{4'd10, 14'b0000001001, 8'hf7},
		'{4'd11, 14'b00010101100, 8'h08}, '{4'd11, 14'b00010010101, 8'h09},
		'{4'd11, 14'b00010001010, 8'h0a}, '{4'd11, 14'b00001110111, 8'h1b},
		'{4'd11, 14'b00001101011, 8'h1d}, '{4'd11, 14'b00010100001, 8'h28},
		'{4'd11, 14'b00001111111, 8'h2a}, '{4'd11, 14'b00001110101, 8'h2b},
		'{4'd11, 14'b00001101110, 8'h2c}, '{4'd11, 14'b00010011110, 8'h38},
		'{4'd11, 14'b00010001100, 8'h39}, '{4'd11, 14'b00010110011, 8'h46},
		'{4'd11, 14'b00010100100, 8'h47}, '{4'd11, 14'b00010011011, 8'h48},
		'{4'd11, 14'b00010111001, 8'h55}, '{4'd11, 14'b00010101101, 8'h56},
		'{4'd11, 14'b00010001110, 8'h58}, '{4'd11, 14'b00010111000, 8'h64},
		'{4'd11, 14'b00010110010, 8'h65}, '{4'd11, 14'b00010100000, 8'h66},
		'{4'd11, 14'b00010000101, 8'h67}, '{4'd11, 14'b00010100101, 8'h74},
		'{4'd11, 14'b00010011101, 8'h75}, '{4'd11, 14'b00010010100, 8'h76},
		'{4'd11, 14'b00010011111, 8'h83}, '{4'd11, 14'b00010011100, 8'h84},
		'{4'd11, 14'b00010001111, 8'h85}, '{4'd11, 14'b00010011010, 8'h90},
		'{4'd11, 14'b00010001101, 8'h93}, '{4'd11, 14'b00010000011, 8'h94},
		'{4'd11, 14'b00000001011, 8'h9f}, '{4'd11, 14'b00010001011, 8'ha0},
		'{4'd11, 14'b00010000001, 8'ha1}, '{4'd11, 14'b00001111101, 8'ha3},
		'{4'd11, 14'b00001111000, 8'hb1}, '{4'd11, 14'b00001110110, 8'hb2},
		'{4'd11, 14'b00001110011, 8'hb3}, '{4'd11, 14'b00000000110, 8'hbf},
		'{4'd11, 14'b00000000100, 8'hcf}, '{4'd11, 14'b00000000010, 8'hdf},
		'{4'd11, 14'b00001100110, 8'he2}, '{4'd11, 14'b00000000000, 8'hef},
		'{4'd11, 14'b00000001101, 8'hf8}, '{4'd11, 14'b00000001100, 8'hf9},
		'{4'd11, 14'b00000001010, 8'hfa}, '{4'd11, 14'b00000000111, 8'hfb},
		'{4'd11, 14'b00000000101, 8'hfc}, '{4'd11, 14'b00000000011, 8'hfd},
		'{4'd11, 14'b00000000001, 8'hfe},
		'{4'd12, 14'b000011110010, 8'h0b}, '{4'd12, 14'b000011100001, 8'h0c},
		'{4'd12, 14'b000011000011, 8'h0d}, '{4'd12, 14'b000011001001, 8'h1c},
		'{4'd12, 14'b000011001111, 8'h1e}, '{4'd12, 14'b000011010001, 8'h2d},
		'{4'd12, 14'b000011001110, 8'h2e}, '{4'd12, 14'b000011111100, 8'h3a},
		'{4'd12, 14'b000011010100, 8'h3b}, '{4'd12, 14'b000011000111, 8'h3c},
		'{4'd12, 14'b000100001000, 8'h49}, '{4'd12, 14'b000011110110, 8'h4a},
		'{4'd12, 14'b000011100010, 8'h4b}, '{4'd12, 14'b000100001001, 8'h57},
		'{4'd12, 14'b000011111101, 8'h59}, '{4'd12, 14'b000011101000, 8'h5a},
		'{4'd12, 14'b000100000001, 8'h68}, '{4'd12, 14'b000011110100, 8'h69},
		'{4'd12, 14'b000011100100, 8'h6a}, '{4'd12, 14'b000011011001, 8'h6b},
		'{4'd12, 14'b000100000101, 8'h77}, '{4'd12, 14'b000011111000, 8'h78},
		'{4'd12, 14'b000100000100, 8'h86}, '{4'd12, 14'b000011111001, 8'h87},
		'{4'd12, 14'b000100000000, 8'h95}, '{4'd12, 14'b000011110101, 8'h96},
		'{4'd12, 14'b000011110111, 8'ha4}, '{4'd12, 14'b000011101001, 8'ha5},
		'{4'd12, 14'b000011100101, 8'ha6}, '{4'd12, 14'b000011011011, 8'ha7},
		'{4'd12, 14'b000011110011, 8'hb0}, '{4'd12, 14'b000011100011, 8'hb4},
		'{4'd12, 14'b000011011111, 8'hb5}, '{4'd12, 14'b000011001010, 8'hc0},
		'{4'd12, 14'b000011100000, 8'hc1}, '{4'd12, 14'b000011011110, 8'hc2},
		'{4'd12, 14'b000011011010, 8'hc3}, '{4'd12, 14'b000011011000, 8'hc4},
		'{4'd12, 14'b000011010011, 8'hd1}, '{4'd12, 14'b000011010010, 8'hd2},
		'{4'd12, 14'b000011010000, 8'hd3}, '{4'd12, 14'b000010111011, 8'he3},
		'{4'd13, 14'b0000101111000, 8'h0e}, '{4'd13, 14'b0000110000011, 8'h3d},
		'{4'd13, 14'b0000101101101, 8'h3e}, '{4'd13, 14'b0000110001011, 8'h4c},
		'{4'd13, 14'b0000101111110, 8'h4d}, '{4'd13, 14'b0000101101010, 8'h4e},
		'{4'd13, 14'b0000110010000, 8'h5b}, '{4'd13, 14'b0000110000100, 8'h5c},
		'{4'd13, 14'b0000101111010, 8'h5d}, '{4'd13, 14'b0000110000001, 8'h6c},
		'{4'd13, 14'b0000101101110, 8'h6d}, '{4'd13, 14'b0000110010111, 8'h79},
		'{4'd13, 14'b0000110001101, 8'h7a}, '{4'd13, 14'b0000101110100, 8'h7b},
		'{4'd13, 14'b0000101111100, 8'h7c}, '{4'd13, 14'b0000110101011, 8'h88},
		'{4'd13, 14'b0000110010001, 8'h89}, '{4'd13, 14'b0000110001000, 8'h8a},
		'{4'd13, 14'b0000101111111, 8'h8b}, '{4'd13, 14'b0000110101010, 8'h97},
		'{4'd13, 14'b0000110010110, 8'h98}, '{4'd13, 14'b0000110001010, 8'h99},
		'{4'd13, 14'b0000110000000, 8'h9a}, '{4'd13, 14'b0000101100111, 8'h9c},
		'{4'd13, 14'b0000101100000, 8'h9e}, '{4'd13, 14'b0000110001001, 8'ha8},
		'{4'd13, 14'b0000110001100, 8'hb6}, '{4'd13, 14'b0000011011111, 8'hbd},
		'{4'd13, 14'b0000110000101, 8'hc5}, '{4'd13, 14'b0000110000010, 8'hc6},
		'{4'd13, 14'b0000101111101, 8'hc7}, '{4'd13, 14'b0000101101100, 8'hc8},
		'{4'd13, 14'b0000101110010, 8'hd4}, '{4'd13, 14'b0000101111011, 8'hd5},
		'{4'd13, 14'b0000101111001, 8'he0}, '{4'd13, 14'b0000101110001, 8'he1},
		'{4'd13, 14'b0000101100110, 8'he6},
		'{4'd14, 14'b00000110111101, 8'h5e}, '{4'd14, 14'b00001011001011, 8'h6e},
		'{4'd14, 14'b00001011010111, 8'h8c}, '{4'd14, 14'b00001011001001, 8'h8d},
		'{4'd14, 14'b00001011000100, 8'h8e}, '{4'd14, 14'b00001011011111, 8'h9b},
		'{4'd14, 14'b00001011000110, 8'h9d}, '{4'd14, 14'b00001011100111, 8'ha9},
		'{4'd14, 14'b00001011100001, 8'haa}, '{4'd14, 14'b00001011010000, 8'hab},
		'{4'd14, 14'b00000110110111, 8'hae}, '{4'd14, 14'b00001011101010, 8'hb7},
		'{4'd14, 14'b00001011100110, 8'hb8}, '{4'd14, 14'b00001011100000, 8'hb9},
		'{4'd14, 14'b00001011010001, 8'hba}, '{4'd14, 14'b00001011001000, 8'hbb},
		'{4'd14, 14'b00001011000010, 8'hbc}, '{4'd14, 14'b00000110110100, 8'hbe},
		'{4'd14, 14'b00000110111011, 8'hca}, '{4'd14, 14'b00001011000011, 8'hcb},
		'{4'd14, 14'b00000110111000, 8'hcc}, '{4'd14, 14'b00000110110101, 8'hcd},
		'{4'd14, 14'b00001011101011, 8'hd0}, '{4'd14, 14'b00001011011110, 8'hd6},
		'{4'd14, 14'b00001011010011, 8'hd7}, '{4'd14, 14'b00001011001010, 8'hd8},
		'{4'd14, 14'b00001011010110, 8'he4}, '{4'd14, 14'b00001011010010, 8'he5},
		'{4'd14, 14'b00001011000111, 8'he7}, '{4'd14, 14'b00001011000101, 8'he8},
		'{4'd14, 14'b00000110110010, 8'hee}
	};

	huff_code_buf_t code_right;

	// Codes are prefix free, so at most one entry hits
	always_comb begin
		code_right = code_buf >> (`HUFF_MAX_CODE_LEN - code_len);
		entry = '0;
		for (int i = 0; i < NUM_CODES; i++) begin
			if (CODES[i].len == code_len && CODES[i].code == code_right) begin
				entry.found = 1'b1;
				entry.x_abs = CODES[i].xy[7:4];
				entry.y_abs = CODES[i].xy[3:0];
			end
		end
	end

endmodule

//--- huff_config.svh
`ifndef HUFF_CONFIG_SVH
`define HUFF_CONFIG_SVH

// Table 21 limits without the 15 to 17 bit codewords
`define HUFF_MAX_CODE_LEN 14
`define HUFF_LINBITS 8
`define HUFF_ESC_VALUE 15

`define HUFF_ABS_W 4
`define HUFF_VAL_W 16

`endif

//--- huff_escape_stage.sv
`timescale 1ns/1ns
`include "huff_config.svh"

module huff_escape_stage (
	input logic clk,
	input logic rst,
	input logic bit_valid,
	input logic bit_data,
	huff_symbol_if.consumer sym,
	output logic pair_valid,
	output huff_pkg::huff_val_t x_val,
	output huff_pkg::huff_val_t y_val
);
	import huff_pkg::*;

	localparam int LIN_CNT_W = $clog2(`HUFF_LINBITS + 1);

	logic [LIN_CNT_W-1:0] x_lin_cnt;
	logic [LIN_CNT_W-1:0] y_lin_cnt;
	logic x_sign_got;
	logic y_sign_got;
	logic [`HUFF_LINBITS-1:0] x_lin;
	logic [`HUFF_LINBITS-1:0] y_lin;
	logic x_sign;
	logic y_sign;
	logic x_lin_need;
	logic x_sign_need;
	logic y_lin_need;
	logic y_sign_need;
	logic take;

	// Linbits only count for an escaped magnitude
	function automatic huff_val_t field_value(huff_abs_t abs_val,
			logic [`HUFF_LINBITS-1:0] lin, logic neg);
		huff_val_t mag;
		mag = huff_val_t'(abs_val);
		if (abs_val == `HUFF_ESC_VALUE)
			mag = mag + huff_val_t'(lin);
		return neg ? -mag : mag;
	endfunction

	//////////////////////////////
	// Suffix field tracking
	//////////////////////////////
	always_comb begin
		x_lin_need = (sym.x_abs == `HUFF_ESC_VALUE) &&
			(x_lin_cnt != LIN_CNT_W'(`HUFF_LINBITS));
		x_sign_need = (sym.x_abs != '0) && !x_sign_got;
		y_lin_need = (sym.y_abs == `HUFF_ESC_VALUE) &&
			(y_lin_cnt != LIN_CNT_W'(`HUFF_LINBITS));
		y_sign_need = (sym.y_abs != '0) && !y_sign_got;
		sym.sym_done = sym.sym_valid &&
			!(x_lin_need || x_sign_need || y_lin_need || y_sign_need);
		take = bit_valid && sym.sym_valid && !sym.sym_done;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			x_lin_cnt <= '0;
			y_lin_cnt <= '0;
			x_sign_got <= 1'b0;
			y_sign_got <= 1'b0;
			pair_valid <= 1'b0;
		end else begin
			pair_valid <= sym.sym_done;
			if (sym.sym_done) begin
				x_lin_cnt <= '0;
				y_lin_cnt <= '0;
				x_sign_got <= 1'b0;
				y_sign_got <= 1'b0;
			end else if (take) begin
				// Field order is x linbits, x sign, y linbits, y sign
				if (x_lin_need)
					x_lin_cnt <= x_lin_cnt + 1'b1;
				else if (x_sign_need)
					x_sign_got <= 1'b1;
				else if (y_lin_need)
					y_lin_cnt <= y_lin_cnt + 1'b1;
				else
					y_sign_got <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// Suffix data and output pair
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (take) begin
			if (x_lin_need)
				x_lin <= {x_lin[`HUFF_LINBITS-2:0], bit_data};
			else if (x_sign_need)
				x_sign <= bit_data;
			else if (y_lin_need)
				y_lin <= {y_lin[`HUFF_LINBITS-2:0], bit_data};
			else
				y_sign <= bit_data;
		end
		if (sym.sym_done) begin
			x_val <= field_value(sym.x_abs, x_lin, x_sign);
			y_val <= field_value(sym.y_abs, y_lin, y_sign);
		end
	end

endmodule

//--- huff_pkg.sv
`include "huff_config.svh"

package huff_pkg;

	typedef logic [`HUFF_ABS_W-1:0] huff_abs_t;

	typedef logic [$clog2(`HUFF_MAX_CODE_LEN + 1)-1:0] huff_code_len_t;

	// First received bit at the MSB
	typedef logic [`HUFF_MAX_CODE_LEN-1:0] huff_code_buf_t;

	typedef struct packed {
		logic found;
		huff_abs_t x_abs;
		huff_abs_t y_abs;
	} huff_entry_t;

	typedef logic signed [`HUFF_VAL_W-1:0] huff_val_t;

endpackage

//--- huff_prefix_stage.sv
`timescale 1ns/1ns
`include "huff_config.svh"

module huff_prefix_stage (
	input logic clk,
	input logic rst,
	input logic bit_valid,
	input logic bit_data,
	huff_symbol_if.producer sym,
	output logic code_error
);
	import huff_pkg::*;

	huff_code_buf_t code_buf;
	huff_code_len_t code_len;
	huff_code_buf_t buf_next;
	huff_code_len_t len_next;
	huff_entry_t entry;
	logic take;

	// Bit is ours when no symbol is held or the held one retires now
	assign take = bit_valid && (!sym.sym_valid || sym.sym_done);

	// New bit lands just below the bits already collected
	assign buf_next = code_buf |
		(huff_code_buf_t'(bit_data) << (`HUFF_MAX_CODE_LEN - 1 - code_len));
	assign len_next = code_len + 1'b1;

	huff_codebook book0 (
		.code_buf(buf_next),
		.code_len(len_next),
		.entry(entry)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			code_buf <= '0;
			code_len <= '0;
			sym.sym_valid <= 1'b0;
			code_error <= 1'b0;
		end else begin
			code_error <= 1'b0;
			if (sym.sym_done)
				sym.sym_valid <= 1'b0;
			if (take) begin
				if (entry.found) begin
					sym.sym_valid <= 1'b1;
					code_buf <= '0;
					code_len <= '0;
				end else if (len_next == `HUFF_MAX_CODE_LEN) begin
					// Nothing matched in 14 bits so matching starts over
					code_error <= 1'b1;
					code_buf <= '0;
					code_len <= '0;
				end else begin
					code_buf <= buf_next;
					code_len <= len_next;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && entry.found) begin
			sym.x_abs <= entry.x_abs;
			sym.y_abs <= entry.y_abs;
		end
	end

endmodule

//--- huff_symbol_if.sv
`timescale 1ns/1ns

interface huff_symbol_if;
	import huff_pkg::*;

	logic sym_valid;
	huff_abs_t x_abs;
	huff_abs_t y_abs;
	// Symbol retires in the cycle this is high
	logic sym_done;

	modport producer (
		output sym_valid,
		output x_abs,
		output y_abs,
		input sym_done
	);

	modport consumer (
		input sym_valid,
		input x_abs,
		input y_abs,
		output sym_done
	);

endinterface
